/* verilog/pq_pkg.sv */
package pq_pkg;

    //////////////////////////////
    // Item fields and heap size
    localparam int KEY_WIDTH   = 16;
    localparam int VAL_WIDTH   = 16;
    localparam int KV_WIDTH    = KEY_WIDTH + VAL_WIDTH;
    localparam int PQ_CAPACITY = 16;
    localparam int ADDR_WIDTH  = 4;
    // One more bit than the address so a full heap is countable
    localparam int CNT_WIDTH   = 5;

    typedef logic [KEY_WIDTH-1:0]  key_t;
    typedef logic [VAL_WIDTH-1:0]  val_t;
    // Key in the upper half, value in the lower half
    typedef logic [KV_WIDTH-1:0]   kv_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [CNT_WIDTH-1:0]  cnt_t;

    // Filler item for a slot with no data
    localparam key_t KEYMAX = '1;
    localparam val_t VAL0   = '0;

    //////////////////////////////
    // Encodings
    typedef enum logic [1:0] {
        OP_ENQ  = 2'd0,
        OP_DEQ  = 2'd1,
        OP_REPL = 2'd2
    } pq_op_t;

    // Controller states
    typedef enum logic [2:0] {
        S_RB,
        S_IDLE,
        S_UP_CMP,
        S_DQ_LD,
        S_DN_R,
        S_DN_SEL,
        S_DN_CMP,
        S_WR_T
    } qq_state_t;

    // RAM write data select
    typedef enum logic [1:0] {
        SB_RAM  = 2'd0,
        SB_TEMP = 2'd1,
        SB_IN   = 2'd2,
        SB_FILL = 2'd3
    } sel_b_t;

endpackage

/* verilog/mem2p_sw_sr.sv */
`timescale 1ns/1ns

module mem2p_sw_sr (
    input  logic          clk,
    input  logic          we_i,
    input  pq_pkg::addr_t wr_addr_i,
    input  pq_pkg::kv_t   wr_data_i,
    input  pq_pkg::addr_t rd_addr_i,
    output pq_pkg::kv_t   rd_data_o
);

    // Heap storage, one item per slot
    pq_pkg::kv_t mem [pq_pkg::PQ_CAPACITY];

    // Write port
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read port
    // Same address as a write in this cycle gives the old item
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* verilog/qq_control.sv */
`timescale 1ns/1ns

module qq_control (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           enq_i,
    input  logic           deq_i,
    input  logic           repl_i,
    input  logic           t_gt_ram_out_i,
    input  logic           c_gt_ram_out_i,
    output logic           sel_t_o,
    output logic           ld_t_o,
    output logic           ld_c_o,
    output logic           we_o,
    output pq_pkg::sel_b_t sel_b_o,
    output pq_pkg::addr_t  rd_addr_o,
    output pq_pkg::addr_t  wr_addr_o,
    output logic           rdy_o,
    output logic           full_o,
    output logic           empty_o
);

    pq_pkg::qq_state_t state_q;
    pq_pkg::qq_state_t state_d;
    // Cursor on the slot that holds the hole
    pq_pkg::addr_t     cur_q;
    pq_pkg::addr_t     cur_d;
    // Child picked for the last compare
    pq_pkg::addr_t     pick_q;
    pq_pkg::addr_t     pick_d;
    pq_pkg::cnt_t      cnt_q;
    pq_pkg::cnt_t      cnt_d;

    // Index math one bit wider than the count
    logic [pq_pkg::CNT_WIDTH:0] cnt_ext;
    logic [pq_pkg::CNT_WIDTH:0] cur_lt;
    logic [pq_pkg::CNT_WIDTH:0] cur_rt;
    logic [pq_pkg::CNT_WIDTH:0] dn_lt;
    pq_pkg::addr_t              cur_up;
    pq_pkg::addr_t              dn_to;

    // Step flags
    logic go_dn;
    logic fin;

    function automatic logic [pq_pkg::CNT_WIDTH:0] lt_of(input pq_pkg::addr_t a);
        return {1'b0, a, 1'b1};
    endfunction

    function automatic pq_pkg::addr_t par_of(input pq_pkg::addr_t a);
        pq_pkg::addr_t am1;
        am1 = a - 1'b1;
        return am1 >> 1;
    endfunction

    assign cnt_ext = {1'b0, cnt_q};
    assign cur_lt  = lt_of(cur_q);
    assign cur_rt  = cur_lt + 1'b1;
    assign cur_up  = par_of(cur_q);

    // Right child goes down straight from the select step
    assign dn_to = (state_q == pq_pkg::S_DN_SEL) ? cur_rt[pq_pkg::ADDR_WIDTH-1:0] : pick_q;
    assign dn_lt = lt_of(dn_to);

    assign rdy_o   = (state_q == pq_pkg::S_IDLE);
    assign full_o  = (cnt_q == pq_pkg::cnt_t'(pq_pkg::PQ_CAPACITY));
    assign empty_o = (cnt_q == '0);

    //////////////////////////////
    // Sequencer
    always_comb begin
        state_d   = state_q;
        cur_d     = cur_q;
        pick_d    = pick_q;
        cnt_d     = cnt_q;
        sel_t_o   = 1'b0;
        ld_t_o    = 1'b0;
        ld_c_o    = 1'b0;
        we_o      = 1'b0;
        sel_b_o   = pq_pkg::SB_TEMP;
        // Root on the read port unless a step needs another slot
        rd_addr_o = '0;
        wr_addr_o = cur_q;
        go_dn     = 1'b0;
        fin       = 1'b0;

        case (state_q)
            // Root read back before going idle
            pq_pkg::S_RB: begin
                state_d = pq_pkg::S_IDLE;
            end

            pq_pkg::S_IDLE: begin
                if (enq_i) begin
                    if (full_o) begin
                        // Dropped
                        state_d = pq_pkg::S_RB;
                    end else begin
                        // New item into temp, hole at the first free slot
                        ld_t_o = 1'b1;
                        cur_d  = cnt_q[pq_pkg::ADDR_WIDTH-1:0];
                        cnt_d  = cnt_q + 1'b1;
                        if (empty_o) begin
                            state_d = pq_pkg::S_WR_T;
                        end else begin
                            rd_addr_o = par_of(cnt_q[pq_pkg::ADDR_WIDTH-1:0]);
                            state_d   = pq_pkg::S_UP_CMP;
                        end
                    end
                end else if (deq_i) begin
                    if (empty_o) begin
                        state_d = pq_pkg::S_RB;
                    end else begin
                        // Fetch the last item, it refills the root
                        rd_addr_o = pq_pkg::addr_t'(cnt_q - 1'b1);
                        cnt_d     = cnt_q - 1'b1;
                        cur_d     = '0;
                        state_d   = pq_pkg::S_DQ_LD;
                    end
                end else if (repl_i) begin
                    if (empty_o) begin
                        state_d = pq_pkg::S_RB;
                    end else begin
                        // Incoming item replaces the root, count kept
                        ld_t_o = 1'b1;
                        cur_d  = '0;
                        if (cnt_q > pq_pkg::cnt_t'(1)) begin
                            rd_addr_o = pq_pkg::addr_t'(1);
                            state_d   = pq_pkg::S_DN_R;
                        end else begin
                            state_d = pq_pkg::S_WR_T;
                        end
                    end
                end
            end

            // Parent on the read port
            pq_pkg::S_UP_CMP: begin
                if (!t_gt_ram_out_i) begin
                    // Parent moves down into the hole
                    // Equal keys move as well
                    we_o    = 1'b1;
                    sel_b_o = pq_pkg::SB_RAM;
                    cur_d   = cur_up;
                    if (cur_up == '0) begin
                        state_d = pq_pkg::S_WR_T;
                    end else begin
                        rd_addr_o = par_of(cur_up);
                    end
                end else begin
                    fin = 1'b1;
                end
            end

            // Last item on the read port
            pq_pkg::S_DQ_LD: begin
                ld_t_o    = 1'b1;
                sel_t_o   = 1'b1;
                // Vacated slot gets the filler
                we_o      = 1'b1;
                sel_b_o   = pq_pkg::SB_FILL;
                wr_addr_o = cnt_q[pq_pkg::ADDR_WIDTH-1:0];
                if (empty_o) begin
                    state_d = pq_pkg::S_RB;
                end else if (cnt_q > pq_pkg::cnt_t'(1)) begin
                    rd_addr_o = pq_pkg::addr_t'(1);
                    state_d   = pq_pkg::S_DN_R;
                end else begin
                    state_d = pq_pkg::S_WR_T;
                end
            end

            // Left child on the read port
            pq_pkg::S_DN_R: begin
                ld_c_o = 1'b1;
                if (cur_rt < cnt_ext) begin
                    rd_addr_o = cur_rt[pq_pkg::ADDR_WIDTH-1:0];
                    state_d   = pq_pkg::S_DN_SEL;
                end else begin
                    // No right child, read the left again
                    rd_addr_o = cur_lt[pq_pkg::ADDR_WIDTH-1:0];
                    pick_d    = cur_lt[pq_pkg::ADDR_WIDTH-1:0];
                    state_d   = pq_pkg::S_DN_CMP;
                end
            end

            // Right child on the read port, left in the child register
            pq_pkg::S_DN_SEL: begin
                if (c_gt_ram_out_i) begin
                    pick_d = dn_to;
                    if (t_gt_ram_out_i) begin
                        go_dn = 1'b1;
                    end else begin
                        fin = 1'b1;
                    end
                end else begin
                    rd_addr_o = cur_lt[pq_pkg::ADDR_WIDTH-1:0];
                    pick_d    = cur_lt[pq_pkg::ADDR_WIDTH-1:0];
                    state_d   = pq_pkg::S_DN_CMP;
                end
            end

            // Picked child on the read port
            pq_pkg::S_DN_CMP: begin
                if (t_gt_ram_out_i) begin
                    go_dn = 1'b1;
                end else begin
                    fin = 1'b1;
                end
            end

            pq_pkg::S_WR_T: begin
                fin = 1'b1;
            end

            default: begin
                state_d = pq_pkg::S_RB;
            end
        endcase

        // Child moves up into the hole, next left child fetched at once
        if (go_dn) begin
            we_o    = 1'b1;
            sel_b_o = pq_pkg::SB_RAM;
            cur_d   = dn_to;
            if (dn_lt < cnt_ext) begin
                rd_addr_o = dn_lt[pq_pkg::ADDR_WIDTH-1:0];
                state_d   = pq_pkg::S_DN_R;
            end else begin
                state_d = pq_pkg::S_WR_T;
            end
        end

        // Temp settles in the hole
        if (fin) begin
            we_o    = 1'b1;
            sel_b_o = pq_pkg::SB_TEMP;
            state_d = pq_pkg::S_RB;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= pq_pkg::S_RB;
            cur_q   <= '0;
            pick_q  <= '0;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cur_q   <= cur_d;
            pick_q  <= pick_d;
            cnt_q   <= cnt_d;
        end
    end

endmodule

/* verilog/qq_node.sv */
`timescale 1ns/1ns

module qq_node (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        enq_i,
    input  logic        deq_i,
    input  logic        repl_i,
    input  pq_pkg::kv_t data_lt_i,
    input  pq_pkg::kv_t data_rt_i,
    output logic        rdy_o,
    output logic        full_o,
    output logic        empty_o,
    output pq_pkg::kv_t data_lt_o,
    output pq_pkg::kv_t data_rt_o
);

    pq_pkg::kv_t    ram_out;
    pq_pkg::kv_t    temp_q;
    pq_pkg::kv_t    child_q;
    pq_pkg::kv_t    item_in;
    pq_pkg::kv_t    t_src;
    pq_pkg::kv_t    wr_data;
    pq_pkg::key_t   ram_key;
    pq_pkg::key_t   temp_key;
    pq_pkg::key_t   child_key;

    // Controller handshake
    logic           sel_t;
    logic           ld_t;
    logic           ld_c;
    logic           we;
    logic           t_gt_ram_out;
    logic           c_gt_ram_out;
    pq_pkg::sel_b_t sel_b;
    pq_pkg::addr_t  rd_addr;
    pq_pkg::addr_t  wr_addr;

    //////////////////////////////
    // Temp and child registers
    // Replace brings its item on the right port
    assign item_in = repl_i ? data_rt_i : data_lt_i;
    assign t_src   = sel_t ? ram_out : item_in;

    always_ff @(posedge clk) begin
        if (ld_t) begin
            temp_q <= t_src;
        end
        if (ld_c) begin
            child_q <= ram_out;
        end
    end

    // Key comparators
    assign ram_key      = ram_out[pq_pkg::KV_WIDTH-1 -: pq_pkg::KEY_WIDTH];
    assign temp_key     = temp_q[pq_pkg::KV_WIDTH-1 -: pq_pkg::KEY_WIDTH];
    assign child_key    = child_q[pq_pkg::KV_WIDTH-1 -: pq_pkg::KEY_WIDTH];
    assign t_gt_ram_out = (temp_key > ram_key);
    assign c_gt_ram_out = (child_key > ram_key);

    // RAM write data
    always_comb begin
        case (sel_b)
            pq_pkg::SB_RAM:  wr_data = ram_out;
            pq_pkg::SB_TEMP: wr_data = temp_q;
            pq_pkg::SB_IN:   wr_data = item_in;
            default:         wr_data = {pq_pkg::KEYMAX, pq_pkg::VAL0};
        endcase
    end

    mem2p_sw_sr bram (
        .clk       (clk),
        .we_i      (we),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (ram_out)
    );

    qq_control ctl (
        .clk            (clk),
        .reset_i        (reset_i),
        .enq_i          (enq_i),
        .deq_i          (deq_i),
        .repl_i         (repl_i),
        .t_gt_ram_out_i (t_gt_ram_out),
        .c_gt_ram_out_i (c_gt_ram_out),
        .sel_t_o        (sel_t),
        .ld_t_o         (ld_t),
        .ld_c_o         (ld_c),
        .we_o           (we),
        .sel_b_o        (sel_b),
        .rd_addr_o      (rd_addr),
        .wr_addr_o      (wr_addr),
        .rdy_o          (rdy_o),
        .full_o         (full_o),
        .empty_o        (empty_o)
    );

    // Root while idle
    assign data_lt_o = ram_out;
    assign data_rt_o = temp_q;

endmodule

/* verilog/pq_cmd_fifo.sv */
`timescale 1ns/1ns

module pq_cmd_fifo #(
    parameter int DEPTH = 4
) (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           push_i,
    input  pq_pkg::pq_op_t push_op_i,
    input  pq_pkg::kv_t    push_kv_i,
    input  logic           pop_i,
    output pq_pkg::pq_op_t head_op_o,
    output pq_pkg::kv_t    head_kv_o,
    output logic           full_o,
    output logic           empty_o
);

    pq_pkg::pq_op_t op_mem [DEPTH];
    pq_pkg::kv_t    kv_mem [DEPTH];

    logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
    logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
    logic [$clog2(DEPTH+1)-1:0] fill_q;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign full_o  = (fill_q == ($clog2(DEPTH+1))'(DEPTH));
    assign empty_o = (fill_q == '0);

    // Head straight from storage
    assign head_op_o = op_mem[rd_ptr_q];
    assign head_kv_o = kv_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr_q] <= push_op_i;
            kv_mem[wr_ptr_q] <= push_kv_i;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Push and pop together keep the fill
            case ({do_push, do_pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
        end
    end

endmodule

/* verilog/pq_top.sv */
`timescale 1ns/1ns

module pq_top (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           cmd_valid_i,
    input  pq_pkg::pq_op_t cmd_op_i,
    input  pq_pkg::kv_t    cmd_kv_i,
    output logic           cmd_ready_o,
    output pq_pkg::kv_t    min_o,
    output logic           full_o,
    output logic           empty_o,
    output logic           idle_o
);

    pq_pkg::pq_op_t head_op;
    pq_pkg::kv_t    head_kv;
    logic           fifo_full;
    logic           fifo_empty;
    logic           node_rdy;
    logic           issue;
    logic           enq;
    logic           deq;
    logic           repl;

    assign cmd_ready_o = !fifo_full;

    // Head goes to the node when both sides are ready
    assign issue = !fifo_empty && node_rdy;
    assign enq   = issue && (head_op == pq_pkg::OP_ENQ);
    assign deq   = issue && (head_op == pq_pkg::OP_DEQ);
    assign repl  = issue && (head_op == pq_pkg::OP_REPL);

    assign idle_o = fifo_empty && node_rdy;

    pq_cmd_fifo #(
        .DEPTH (4)
    ) cmd_fifo (
        .clk       (clk),
        .reset_i   (reset_i),
        .push_i    (cmd_valid_i && cmd_ready_o),
        .push_op_i (cmd_op_i),
        .push_kv_i (cmd_kv_i),
        .pop_i     (issue),
        .head_op_o (head_op),
        .head_kv_o (head_kv),
        .full_o    (fifo_full),
        .empty_o   (fifo_empty)
    );

    // Same item on both ports, the strobe picks the use
    qq_node node (
        .clk       (clk),
        .reset_i   (reset_i),
        .enq_i     (enq),
        .deq_i     (deq),
        .repl_i    (repl),
        .data_lt_i (head_kv),
        .data_rt_i (head_kv),
        .rdy_o     (node_rdy),
        .full_o    (full_o),
        .empty_o   (empty_o),
        .data_lt_o (min_o),
        .data_rt_o ()
    );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);

    // Free running clock
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Reset held over the first rising edges, released on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

/* tests/pq_assertions.sv */
`timescale 1ns/1ns

module pq_assertions (
    input logic clk,
    input logic reset_i,
    input logic rdy_i,
    input logic full_i,
    input logic empty_i,
    input logic we_i,
    input logic enq_i,
    input logic deq_i,
    input logic repl_i
);

    // Running count of failed assertions
    int fail_cnt = 0;

    // Root read back, then ready
    rdy_after_reset: assert property (@(posedge clk) $fell(reset_i) |=> rdy_i)
        else begin
            fail_cnt++;
            $error("rdy_o not high one cycle after reset release");
        end

    // Count cannot be zero and at capacity at once
    flags_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(full_i && empty_i))
        else begin
            fail_cnt++;
            $error("full_o and empty_o both high");
        end

    // No RAM write while waiting for an operation
    no_write_when_ready: assert property (@(posedge clk) disable iff (reset_i)
        rdy_i |-> !we_i)
        else begin
            fail_cnt++;
            $error("RAM write while rdy_o is high");
        end

    // Strobes only into an idle node
    no_strobe_when_busy: assert property (@(posedge clk) disable iff (reset_i)
        !rdy_i |-> !(enq_i || deq_i || repl_i))
        else begin
            fail_cnt++;
            $error("operation strobe while rdy_o is low");
        end

endmodule

bind qq_node pq_assertions chk (
    .clk     (clk),
    .reset_i (reset_i),
    .rdy_i   (rdy_o),
    .full_i  (full_o),
    .empty_i (empty_o),
    .we_i    (we),
    .enq_i   (enq_i),
    .deq_i   (deq_i),
    .repl_i  (repl_i)
);

/* tests/pq_tb.sv */
`timescale 1ns/1ns

module pq_tb;

    //////////////////////////////
    // Test sizes
    localparam int FILL_LEN  = pq_pkg::PQ_CAPACITY;
    localparam int HALF_LEN  = pq_pkg::PQ_CAPACITY / 2;
    localparam int REPL_LEN  = 6;
    localparam int BURST_LEN = 12;
    localparam int MIX_LEN   = 300;
    // Tests 1 to 6 in order
    localparam int TOTAL_CMDS = FILL_LEN + FILL_LEN + (HALF_LEN + REPL_LEN)
                              + (HALF_LEN + 1 + FILL_LEN + 3) + BURST_LEN + MIX_LEN;
    localparam int CYCLES_PER_CMD  = 1000;
    // Margin covers reset and the final read back
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS * CYCLES_PER_CMD + 2000;

    logic           clk;
    logic           reset;
    logic           cmd_valid;
    pq_pkg::pq_op_t cmd_op;
    pq_pkg::kv_t    cmd_kv;
    logic           cmd_ready;
    pq_pkg::kv_t    min_kv;
    logic           full;
    logic           empty;
    logic           idle;

    // Unordered model of the heap contents
    pq_pkg::key_t   m_key [pq_pkg::PQ_CAPACITY];
    pq_pkg::val_t   m_val [pq_pkg::PQ_CAPACITY];
    int             m_cnt;

    // Root seen at the last check
    pq_pkg::kv_t    last_min;
    logic [31:0]    rng_state;
    int             checks;
    int             errors;
    int             test_checks0;
    int             test_errors0;

    tb_clock_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (16)
    ) clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    pq_top UUT (
        .clk         (clk),
        .reset_i     (reset),
        .cmd_valid_i (cmd_valid),
        .cmd_op_i    (cmd_op),
        .cmd_kv_i    (cmd_kv),
        .cmd_ready_o (cmd_ready),
        .min_o       (min_kv),
        .full_o      (full),
        .empty_o     (empty),
        .idle_o      (idle)
    );

    //////////////////////////////
    // Random numbers and items
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic pq_pkg::key_t key_of(input pq_pkg::kv_t kv);
        return kv[pq_pkg::KV_WIDTH-1 -: pq_pkg::KEY_WIDTH];
    endfunction

    function automatic pq_pkg::val_t val_of(input pq_pkg::kv_t kv);
        return kv[pq_pkg::VAL_WIDTH-1:0];
    endfunction

    // Narrow keys give many equal keys
    task automatic rand_kv(input logic narrow, output pq_pkg::kv_t kv);
        logic [31:0]  r;
        pq_pkg::key_t k;
        next_rand(r);
        k = narrow ? pq_pkg::key_t'(r[23:16]) : r[31:16];
        // All-ones key is the filler
        if (k == pq_pkg::KEYMAX) begin
            k = pq_pkg::KEYMAX - 1'b1;
        end
        kv = {k, r[15:0]};
    endtask

    //////////////////////////////
    // Heap model
    function automatic pq_pkg::key_t model_min_key();
        pq_pkg::key_t k;
        k = pq_pkg::KEYMAX;
        for (int i = 0; i < m_cnt; i++) begin
            if (m_key[i] < k) begin
                k = m_key[i];
            end
        end
        return k;
    endfunction

    function automatic int model_min_index();
        int idx;
        idx = 0;
        for (int i = 1; i < m_cnt; i++) begin
            if (m_key[i] < m_key[idx]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic int model_find(input pq_pkg::key_t k, input pq_pkg::val_t v);
        int idx;
        idx = -1;
        for (int i = 0; i < m_cnt; i++) begin
            if (m_key[i] == k && m_val[i] == v) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // Full heap drops the item
    task automatic model_push(input pq_pkg::kv_t kv);
        if (m_cnt < pq_pkg::PQ_CAPACITY) begin
            m_key[m_cnt] = key_of(kv);
            m_val[m_cnt] = val_of(kv);
            m_cnt++;
        end
    endtask

    // The DUT removes the root it showed at the last check
    task automatic model_take_root();
        int idx;
        idx = model_find(key_of(last_min), val_of(last_min));
        // Root missing from the model was already flagged at its check
        if (idx < 0) begin
            idx = model_min_index();
        end
        m_key[idx] = m_key[m_cnt-1];
        m_val[idx] = m_val[m_cnt-1];
        m_cnt--;
    endtask

    //////////////////////////////
    // Host side
    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_cmd(input pq_pkg::pq_op_t op, input pq_pkg::kv_t kv);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_kv    = kv;
        // Ready is stable from here to the next rising edge
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!idle) begin
            @(negedge clk);
        end
    endtask

    task automatic check_state(input string what);
        pq_pkg::key_t dut_key;
        pq_pkg::val_t dut_val;
        dut_key = key_of(min_kv);
        dut_val = val_of(min_kv);
        checks++;
        if (empty !== (m_cnt == 0)) begin
            errors++;
            $display("Fail %0t ns: %s, empty_o is %b with %0d items in the model",
                     $time, what, empty, m_cnt);
        end
        checks++;
        if (full !== (m_cnt == pq_pkg::PQ_CAPACITY)) begin
            errors++;
            $display("Fail %0t ns: %s, full_o is %b with %0d items in the model",
                     $time, what, full, m_cnt);
        end
        if (m_cnt != 0) begin
            checks++;
            if (dut_key !== model_min_key()) begin
                errors++;
                $display("Fail %0t ns: %s, min key %h but model smallest is %h",
                         $time, what, dut_key, model_min_key());
            end
            checks++;
            if (model_find(dut_key, dut_val) < 0) begin
                errors++;
                $display("Fail %0t ns: %s, min item %h:%h is not in the model",
                         $time, what, dut_key, dut_val);
            end
        end
        last_min = min_kv;
    endtask

    task automatic apply_enq(input string what, input pq_pkg::kv_t kv);
        model_push(kv);
        send_cmd(pq_pkg::OP_ENQ, kv);
        wait_idle();
        check_state(what);
    endtask

    task automatic apply_deq(input string what, output logic took,
                             output pq_pkg::kv_t removed);
        took    = (m_cnt != 0);
        removed = last_min;
        if (took) begin
            model_take_root();
        end
        send_cmd(pq_pkg::OP_DEQ, '0);
        wait_idle();
        check_state(what);
    endtask

    // Old minimum out, new item in
    task automatic apply_repl(input string what, input pq_pkg::kv_t kv);
        if (m_cnt != 0) begin
            model_take_root();
            model_push(kv);
        end
        send_cmd(pq_pkg::OP_REPL, kv);
        wait_idle();
        check_state(what);
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s: %0d checks, %0d errors", num, name,
                 checks - test_checks0, errors - test_errors0);
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    //////////////////////////////
    // Main sequence
    initial begin
        logic         took;
        pq_pkg::kv_t  kv;
        pq_pkg::kv_t  removed;
        pq_pkg::key_t prev_key;
        logic [31:0]  r;
        int           stalls;
        int           sent;
        int           afails;
        pq_pkg::kv_t  burst_kv [BURST_LEN];

        cmd_valid    = 1'b0;
        cmd_op       = pq_pkg::OP_ENQ;
        cmd_kv       = '0;
        rng_state    = 32'hbca1_3c4d;
        m_cnt        = 0;
        last_min     = '0;
        checks       = 0;
        errors       = 0;
        test_checks0 = 0;
        test_errors0 = 0;

        wait (reset == 1'b0);
        @(negedge clk);
        wait_idle();
        check_state("after reset");
        // Empty FIFO takes commands
        checks++;
        if (cmd_ready !== 1'b1) begin
            errors++;
            $display("Fail %0t ns: after reset, cmd_ready_o is %b", $time, cmd_ready);
        end

        // 1. Fill
        for (int i = 0; i < FILL_LEN; i++) begin
            rand_kv(1'b0, kv);
            apply_enq("fill enqueue", kv);
        end
        end_test(1, "fill with enqueues");

        // 2. Drain, keys must not decrease
        prev_key = '0;
        for (int i = 0; i < FILL_LEN; i++) begin
            apply_deq("drain dequeue", took, removed);
            if (took) begin
                checks++;
                if (key_of(removed) < prev_key) begin
                    errors++;
                    $display("Fail %0t ns: dequeued key %h after key %h",
                             $time, key_of(removed), prev_key);
                end
                prev_key = key_of(removed);
            end
        end
        end_test(2, "drain with dequeues");

        // 3. Replace on a half-full heap
        for (int i = 0; i < HALF_LEN; i++) begin
            rand_kv(1'b0, kv);
            apply_enq("half fill enqueue", kv);
        end
        for (int i = 0; i < REPL_LEN; i++) begin
            rand_kv(1'b0, kv);
            apply_repl("replace", kv);
        end
        end_test(3, "replace on half-full heap");

        // 4. Overflow, then underflow
        for (int i = 0; i < HALF_LEN; i++) begin
            rand_kv(1'b0, kv);
            apply_enq("top up enqueue", kv);
        end
        rand_kv(1'b0, kv);
        apply_enq("enqueue on full heap", kv);
        for (int i = 0; i < FILL_LEN; i++) begin
            apply_deq("empty out dequeue", took, removed);
        end
        apply_deq("dequeue on empty heap", took, removed);
        apply_deq("dequeue on empty heap", took, removed);
        rand_kv(1'b0, kv);
        apply_repl("replace on empty heap", kv);
        end_test(4, "overflow and underflow");

        // 5. Back-to-back enqueues with valid held high
        for (int i = 0; i < BURST_LEN; i++) begin
            rand_kv(1'b0, burst_kv[i]);
        end
        stalls = 0;
        sent   = 0;
        while (sent < BURST_LEN) begin
            cmd_valid = 1'b1;
            cmd_op    = pq_pkg::OP_ENQ;
            cmd_kv    = burst_kv[sent];
            if (cmd_ready) begin
                model_push(burst_kv[sent]);
                sent++;
            end else begin
                stalls++;
            end
            @(negedge clk);
        end
        cmd_valid = 1'b0;
        checks++;
        if (stalls == 0) begin
            errors++;
            $display("Back-pressure failure: cmd_ready_o never dropped during the burst");
        end
        wait_idle();
        check_state("after burst");
        end_test(5, "back-pressure burst");

        // 6. Random mix over narrow keys
        for (int i = 0; i < MIX_LEN; i++) begin
            next_rand(r);
            rand_kv(1'b1, kv);
            if (r[2:0] < 3'd3) begin
                apply_enq("mix enqueue", kv);
            end else if (r[2:0] < 3'd6) begin
                apply_deq("mix dequeue", took, removed);
            end else begin
                apply_repl("mix replace", kv);
            end
        end
        end_test(6, "random mix");

        afails = UUT.node.chk.fail_cnt;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* verilog.f */
verilog/pq_pkg.sv
verilog/mem2p_sw_sr.sv
verilog/qq_control.sv
verilog/qq_node.sv
verilog/pq_cmd_fifo.sv
verilog/pq_top.sv
tests/tb_clock_gen.sv
tests/pq_assertions.sv
tests/pq_tb.sv
